// File: include/tcdm_ecc_cfg.svh
// tcdm ecc scratchpad configuration
// lane count, bank geometry and code word widths shared by rtl and testbench
`ifndef TCDM_ECC_CFG_SVH
`define TCDM_ECC_CFG_SVH

`define TCDM_NB_LANES   4
`define TCDM_NB_BANKS   8   // must stay a power of two
`define TCDM_BANK_DEPTH 64
`define TCDM_DATA_W     32
`define TCDM_PAR_W      7

// derived widths
`define TCDM_BSEL_W ($clog2(`TCDM_NB_BANKS))
`define TCDM_ROW_W  ($clog2(`TCDM_BANK_DEPTH))
`define TCDM_ADDR_W (`TCDM_BSEL_W + `TCDM_ROW_W)   // word address

`endif

// File: rtl/tcdm_ecc_pkg.sv
// SEC-DED code types for the scratchpad
// code word layout, decode status and the Hsiao check matrix columns
`include "tcdm_ecc_cfg.svh"

package tcdm_ecc_pkg;

  typedef struct packed {
    logic [`TCDM_DATA_W-1:0] data;
    logic [`TCDM_PAR_W-1:0]  parity;
  } code_word_t;

  // ordered by severity, merge picks the largest
  typedef enum logic [1:0] {
    ECC_OK            = 2'd0,
    ECC_CORRECTED     = 2'd1,
    ECC_UNCORRECTABLE = 2'd2
  } ecc_status_e;

  // column of data bit idx: the idx-th weight-3 pattern in ascending order
  function automatic logic [`TCDM_PAR_W-1:0] hsiao_col(input int unsigned idx);
    int unsigned                n;
    logic [`TCDM_PAR_W-1:0]     cand;
    logic [`TCDM_PAR_W-1:0]     col;
    n   = 0;
    col = '0;
    for (int unsigned v = 0; v < (1 << `TCDM_PAR_W); v++) begin
      cand = (`TCDM_PAR_W)'(v);
      if ($countones(cand) == 3) begin
        if (n == idx) col = cand;
        n++;
      end
    end
    return col;
  endfunction

endpackage

// File: rtl/tcdm_bus_pkg.sv
// bus types of the wide access port
// initiator side wide request and response, per lane and per bank
// requests and the bank read response
`include "tcdm_ecc_cfg.svh"

package tcdm_bus_pkg;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } mem_op_e;

  typedef struct packed {
    mem_op_e                                      op;
    logic [`TCDM_ADDR_W-1:0]                      addr;  // start word
    logic [`TCDM_NB_LANES-1:0][`TCDM_DATA_W-1:0]  data;
  } wide_req_t;

  typedef struct packed {
    logic [`TCDM_NB_LANES-1:0][`TCDM_DATA_W-1:0]  data;
    tcdm_ecc_pkg::ecc_status_e                    status;     // worst over lanes
    logic [`TCDM_NB_LANES-1:0]                    corrected;
  } wide_rsp_t;

  typedef struct packed {
    logic [`TCDM_ADDR_W-1:0]  addr;
    tcdm_ecc_pkg::code_word_t cw;
  } lane_req_t;

  typedef struct packed {
    logic [`TCDM_ROW_W-1:0]   row;
    tcdm_ecc_pkg::code_word_t cw;
  } bank_req_t;

  typedef struct packed {
    tcdm_ecc_pkg::code_word_t cw;
  } bank_rsp_t;

endpackage

// File: rtl/ecc_encoder.sv
// SEC-DED encoder for one data word
// Hsiao style code, every data bit covered by three parity bits
`timescale 1ns/1ps
`include "tcdm_ecc_cfg.svh"

module ecc_encoder (
  input  logic [`TCDM_DATA_W-1:0]  data_i,
  output tcdm_ecc_pkg::code_word_t cw_o
);

  import tcdm_ecc_pkg::*;

  logic [`TCDM_PAR_W-1:0] parity;

  // each set data bit toggles the parity bits of its column
  always_comb begin
    parity = '0;
    for (int unsigned i = 0; i < `TCDM_DATA_W; i++) begin
      if (data_i[i]) begin
        parity ^= hsiao_col(i);
      end
    end
  end

  assign cw_o.data   = data_i;
  assign cw_o.parity = parity;

endmodule

// File: rtl/ecc_decoder.sv
// SEC-DED decoder for one code word
// recomputes the syndrome, corrects a single flipped bit and flags
// double errors as uncorrectable
`timescale 1ns/1ps
`include "tcdm_ecc_cfg.svh"

module ecc_decoder (
  input  tcdm_ecc_pkg::code_word_t  cw_i,
  output logic [`TCDM_DATA_W-1:0]   data_o,
  output tcdm_ecc_pkg::ecc_status_e status_o
);

  import tcdm_ecc_pkg::*;

  logic [`TCDM_PAR_W-1:0]  syndrome;
  logic [`TCDM_DATA_W-1:0] flip_mask;   // data bit named by the syndrome
  logic                    par_hit;     // error sits in a parity bit
  logic                    synd_odd;

  always_comb begin
    syndrome = cw_i.parity;
    for (int unsigned i = 0; i < `TCDM_DATA_W; i++) begin
      if (cw_i.data[i]) begin
        syndrome ^= hsiao_col(i);
      end
    end
  end

  // at most one column can match
  always_comb begin
    flip_mask = '0;
    for (int unsigned i = 0; i < `TCDM_DATA_W; i++) begin
      flip_mask[i] = (syndrome == hsiao_col(i));
    end
  end

  assign par_hit  = ($countones(syndrome) == 1);
  assign synd_odd = ^syndrome;
  assign data_o   = cw_i.data ^ flip_mask;

  always_comb begin
    if (syndrome == '0) begin
      status_o = ECC_OK;
    end else if (!synd_odd) begin
      status_o = ECC_UNCORRECTABLE;   // even weight, double error
    end else if (par_hit || (|flip_mask)) begin
      status_o = ECC_CORRECTED;
    end else begin
      // odd weight with no matching column, three or more flips
      status_o = ECC_UNCORRECTABLE;
    end
  end

endmodule

// File: rtl/bank_rotation_router.sv
// lockstep rotating router between the lanes of a wide access and the banks
// lane k goes to bank (order + k) mod NB_BANKS, all banks fire together
// read responses come back one cycle later, rotated back by the saved order
`timescale 1ns/1ps
`include "tcdm_ecc_cfg.svh"

module bank_rotation_router (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          req_i,
  input  tcdm_bus_pkg::mem_op_e                         op_i,
  input  logic [`TCDM_BSEL_W-1:0]                       order_i,
  input  tcdm_bus_pkg::lane_req_t [`TCDM_NB_LANES-1:0]  lane_req_i,
  output logic                                          gnt_o,
  output logic                                          r_valid_o,
  output tcdm_ecc_pkg::code_word_t [`TCDM_NB_LANES-1:0] lane_rdata_o,
  output logic [`TCDM_NB_BANKS-1:0]                     bank_req_o,
  output tcdm_bus_pkg::mem_op_e                         bank_op_o,
  output tcdm_bus_pkg::bank_req_t [`TCDM_NB_BANKS-1:0]  bank_o,
  input  logic [`TCDM_NB_BANKS-1:0]                     bank_gnt_i,
  input  tcdm_bus_pkg::bank_rsp_t [`TCDM_NB_BANKS-1:0]  bank_rdata_i
);

  import tcdm_bus_pkg::*;

  logic [`TCDM_NB_LANES-1:0][`TCDM_NB_BANKS-1:0] lane_sel;  // one-hot per lane
  logic [`TCDM_NB_BANKS-1:0]                     bank_tgt;
  logic                                          accept;
  logic                                          rd_q;
  logic [`TCDM_BSEL_W-1:0]                       order_q;

  for (genvar k = 0; k < `TCDM_NB_LANES; k++) begin : lane_gen
    logic [`TCDM_BSEL_W-1:0] bank_idx;
    logic [`TCDM_BSEL_W-1:0] rsp_idx;

    // wraps naturally since the bank count is a power of two
    assign bank_idx    = order_i + (`TCDM_BSEL_W)'(k);
    assign lane_sel[k] = req_i ? ((`TCDM_NB_BANKS)'(1) << bank_idx) : '0;

    // response side uses the order of the access accepted last cycle
    assign rsp_idx         = order_q + (`TCDM_BSEL_W)'(k);
    assign lane_rdata_o[k] = bank_rdata_i[rsp_idx].cw;
  end

  // OR the selected lanes onto each bank
  always_comb begin
    bank_tgt = '0;
    bank_o   = '0;
    for (int b = 0; b < `TCDM_NB_BANKS; b++) begin
      for (int k = 0; k < `TCDM_NB_LANES; k++) begin
        bank_tgt[b]  |= lane_sel[k][b];
        bank_o[b].row |= lane_sel[k][b] ?
                         lane_req_i[k].addr[`TCDM_ADDR_W-1:`TCDM_BSEL_W] : '0;
        bank_o[b].cw  |= lane_sel[k][b] ? lane_req_i[k].cw : '0;
      end
    end
  end

  // every targeted bank must grant, untargeted banks don't care
  assign gnt_o  = &(~bank_tgt | bank_gnt_i);
  assign accept = req_i & gnt_o;

  // banks only see the request once the whole access goes through
  assign bank_req_o = bank_tgt & {`TCDM_NB_BANKS{gnt_o}};
  assign bank_op_o  = op_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_q    <= 1'b0;
      order_q <= '0;
    end else begin
      rd_q <= accept && (op_i == OP_READ);   // writes give no response
      if (accept) begin
        order_q <= order_i;
      end
    end
  end

  assign r_valid_o = rd_q;   // fixed latency of one

endmodule

// File: rtl/wide_port_frontend.sv
// frontend of the wide access port
// splits the access into lanes, derives the rotation order and encodes
// write data; decodes read lanes and merges their ECC status
`timescale 1ns/1ps
`include "tcdm_ecc_cfg.svh"

module wide_port_frontend (
  input  logic                                          req_i,
  input  tcdm_bus_pkg::wide_req_t                       wide_i,
  output logic                                          gnt_o,
  output logic                                          r_valid_o,
  output tcdm_bus_pkg::wide_rsp_t                       rsp_o,
  output logic                                          lane_strb_o,
  output tcdm_bus_pkg::lane_req_t [`TCDM_NB_LANES-1:0]  lane_req_o,
  output tcdm_bus_pkg::mem_op_e                         lane_op_o,
  output logic [`TCDM_BSEL_W-1:0]                       order_o,
  input  logic                                          lane_gnt_i,
  input  logic                                          lane_r_valid_i,
  input  tcdm_ecc_pkg::code_word_t [`TCDM_NB_LANES-1:0] lane_rdata_i
);

  import tcdm_ecc_pkg::*;

  logic [`TCDM_NB_LANES-1:0][`TCDM_DATA_W-1:0] lane_data;
  ecc_status_e                                 lane_status [`TCDM_NB_LANES];
  logic [`TCDM_NB_LANES-1:0]                   corr_mask;
  ecc_status_e                                 worst_status;

  for (genvar k = 0; k < `TCDM_NB_LANES; k++) begin : lane_gen
    // consecutive words, wrapping at the top of the address space
    assign lane_req_o[k].addr = wide_i.addr + (`TCDM_ADDR_W)'(k);

    ecc_encoder u_enc (
      .data_i ( wide_i.data[k]    ),
      .cw_o   ( lane_req_o[k].cw  )
    );

    ecc_decoder u_dec (
      .cw_i     ( lane_rdata_i[k] ),
      .data_o   ( lane_data[k]    ),
      .status_o ( lane_status[k]  )
    );

    assign corr_mask[k] = (lane_status[k] == ECC_CORRECTED);
  end

  always_comb begin
    worst_status = ECC_OK;
    for (int k = 0; k < `TCDM_NB_LANES; k++) begin
      if (lane_status[k] > worst_status) begin
        worst_status = lane_status[k];
      end
    end
  end

  assign order_o     = wide_i.addr[`TCDM_BSEL_W-1:0];  // bank of lane 0
  assign lane_op_o   = wide_i.op;
  assign lane_strb_o = req_i;   // grant is formed in the router
  assign gnt_o       = lane_gnt_i;
  assign r_valid_o   = lane_r_valid_i;

  assign rsp_o.data      = lane_data;
  assign rsp_o.status    = worst_status;
  assign rsp_o.corrected = corr_mask;

endmodule

// File: rtl/tcdm_bank.sv
// single-port scratchpad bank holding full code words
// grants unless stalled by another master, registers read data on the
// accepting edge and stores writes through a bit-flip injection mask
`timescale 1ns/1ps
`include "tcdm_ecc_cfg.svh"

module tcdm_bank (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     req_i,
  input  tcdm_bus_pkg::mem_op_e    op_i,
  input  tcdm_bus_pkg::bank_req_t  bank_i,
  input  logic                     stall_i,
  input  tcdm_ecc_pkg::code_word_t flip_i,
  output logic                     gnt_o,
  output tcdm_bus_pkg::bank_rsp_t  rsp_o
);

  import tcdm_ecc_pkg::*;
  import tcdm_bus_pkg::*;

  code_word_t mem_q [`TCDM_BANK_DEPTH];
  code_word_t rdata_q;
  logic       wr_en;
  logic       rd_en;

  assign gnt_o = ~stall_i;   // port busy with another master
  assign wr_en = req_i & gnt_o & (op_i == OP_WRITE);
  assign rd_en = req_i & gnt_o & (op_i == OP_READ);

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[bank_i.row] <= bank_i.cw ^ flip_i;   // injected flips land in storage
    end
  end

  // holds the last read word until the next read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (rd_en) begin
      rdata_q <= mem_q[bank_i.row];
    end
  end

  assign rsp_o.cw = rdata_q;

endmodule

// File: rtl/tcdm_ecc_subsystem.sv
// ECC protected shared scratchpad with one wide access port
// frontend, rotating router and NB_BANKS code word banks
`timescale 1ns/1ps
`include "tcdm_ecc_cfg.svh"

module tcdm_ecc_subsystem (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          req_i,
  input  tcdm_bus_pkg::wide_req_t                       wide_i,
  output logic                                          gnt_o,
  output logic                                          r_valid_o,
  output tcdm_bus_pkg::wide_rsp_t                       rsp_o,
  input  logic [`TCDM_NB_BANKS-1:0]                     bank_stall_i,
  input  tcdm_ecc_pkg::code_word_t [`TCDM_NB_BANKS-1:0] inj_flip_i
);

  import tcdm_ecc_pkg::*;
  import tcdm_bus_pkg::*;

  logic                                 lane_strb;
  mem_op_e                              lane_op;
  logic [`TCDM_BSEL_W-1:0]              order;
  lane_req_t [`TCDM_NB_LANES-1:0]       lane_req;
  logic                                 lane_gnt;
  logic                                 lane_r_valid;
  code_word_t [`TCDM_NB_LANES-1:0]      lane_rdata;

  logic [`TCDM_NB_BANKS-1:0]            bank_req;
  mem_op_e                              bank_op;
  bank_req_t [`TCDM_NB_BANKS-1:0]       bank_req_s;
  logic [`TCDM_NB_BANKS-1:0]            bank_gnt;
  bank_rsp_t [`TCDM_NB_BANKS-1:0]       bank_rsp;

  wide_port_frontend u_frontend (
    .req_i          ( req_i        ),
    .wide_i         ( wide_i       ),
    .gnt_o          ( gnt_o        ),
    .r_valid_o      ( r_valid_o    ),
    .rsp_o          ( rsp_o        ),
    .lane_strb_o    ( lane_strb    ),
    .lane_req_o     ( lane_req     ),
    .lane_op_o      ( lane_op      ),
    .order_o        ( order        ),
    .lane_gnt_i     ( lane_gnt     ),
    .lane_r_valid_i ( lane_r_valid ),
    .lane_rdata_i   ( lane_rdata   )
  );

  bank_rotation_router u_router (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .req_i        ( lane_strb    ),
    .op_i         ( lane_op      ),
    .order_i      ( order        ),
    .lane_req_i   ( lane_req     ),
    .gnt_o        ( lane_gnt     ),
    .r_valid_o    ( lane_r_valid ),
    .lane_rdata_o ( lane_rdata   ),
    .bank_req_o   ( bank_req     ),
    .bank_op_o    ( bank_op      ),
    .bank_o       ( bank_req_s   ),
    .bank_gnt_i   ( bank_gnt     ),
    .bank_rdata_i ( bank_rsp     )
  );

  for (genvar b = 0; b < `TCDM_NB_BANKS; b++) begin : bank_gen
    tcdm_bank u_bank (
      .clk_i   ( clk_i           ),
      .rst_ni  ( rst_ni          ),
      .req_i   ( bank_req[b]     ),
      .op_i    ( bank_op         ),
      .bank_i  ( bank_req_s[b]   ),
      .stall_i ( bank_stall_i[b] ),
      .flip_i  ( inj_flip_i[b]   ),
      .gnt_o   ( bank_gnt[b]     ),
      .rsp_o   ( bank_rsp[b]     )
    );
  end

endmodule

// File: tests/tcdm_ecc_props.sv
// concurrent checks on the rotating router
// read responses follow reads sent to the banks and every lane of an
// access lands on a bank of its own
`timescale 1ns/1ps
`include "tcdm_ecc_cfg.svh"

module tcdm_ecc_props (
  input logic                                          clk_i,
  input logic                                          rst_ni,
  input logic                                          req_i,
  input tcdm_bus_pkg::mem_op_e                         op_i,
  input logic                                          gnt_i,
  input logic                                          r_valid_i,
  input logic [`TCDM_NB_LANES-1:0][`TCDM_NB_BANKS-1:0] lane_sel_i,
  input logic [`TCDM_NB_BANKS-1:0]                     bank_req_i
);

  import tcdm_bus_pkg::*;

  int unsigned fail_cnt = 0;   // failed assertions so far
  logic        rd_issue;

  assign rd_issue = (|bank_req_i) && (op_i == OP_READ);   // read sent to the banks

  rvalid_after_read: assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid_i |-> $past(rd_issue))
    else begin
      $error("r_valid without a read sent to the banks one cycle earlier");
      fail_cnt++;
    end

  read_gets_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_issue |=> r_valid_i)
    else begin
      $error("read sent to the banks got no r_valid");
      fail_cnt++;
    end

  // all lanes on distinct banks
  full_fanout: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i && gnt_i) |-> ($countones(bank_req_i) == `TCDM_NB_LANES))
    else begin
      $error("accepted access does not reach one bank per lane");
      fail_cnt++;
    end

  // no bank is shared by two lanes even while stalled
  for (genvar j = 0; j < `TCDM_NB_LANES; j++) begin : lane_a_gen
    for (genvar k = j + 1; k < `TCDM_NB_LANES; k++) begin : lane_b_gen
      lanes_apart: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (lane_sel_i[j] & lane_sel_i[k]) == '0)
        else begin
          $error("lanes %0d and %0d routed to the same bank", j, k);
          fail_cnt++;
        end
    end
  end

endmodule

// File: tests/tcdm_ecc_tb.sv
// testbench for the ECC protected scratchpad
// random wide accesses against a word level reference model, bank stall
// back-pressure and injected single and double bit flips
`timescale 1ns/1ps
`include "tcdm_ecc_cfg.svh"

module tcdm_ecc_tb;

  import tcdm_ecc_pkg::*;
  import tcdm_bus_pkg::*;

  localparam int ADDR_W  = `TCDM_ADDR_W;
  localparam int BSEL_W  = `TCDM_BSEL_W;
  localparam int NWORDS  = 1 << ADDR_W;
  localparam int CW_W    = `TCDM_DATA_W + `TCDM_PAR_W;
  localparam int TIMEOUT = 40;   // cycles to wait for a grant

  typedef logic [ADDR_W-1:0]       addr_t;
  typedef logic [`TCDM_DATA_W-1:0] word_t;

  logic                            clk_i;
  logic                            rst_ni;
  logic                            req_i;
  wide_req_t                       wide_i;
  logic                            gnt_o;
  logic                            r_valid_o;
  wide_rsp_t                       rsp_o;
  logic [`TCDM_NB_BANKS-1:0]       bank_stall_i;
  code_word_t [`TCDM_NB_BANKS-1:0] inj_flip_i;

  word_t     ref_mem [NWORDS];
  integer    seed = 90698;
  int        err_cnt;
  int        test_cnt;
  int        fail_cnt;
  logic      timed_out;
  logic      pend_rd;       // read accepted on the previous edge
  logic      status_only;   // double error so data is not checked
  wide_rsp_t exp_rsp;

  tcdm_ecc_subsystem tcdm_ecc_subsystem_inst (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .req_i        ( req_i        ),
    .wide_i       ( wide_i       ),
    .gnt_o        ( gnt_o        ),
    .r_valid_o    ( r_valid_o    ),
    .rsp_o        ( rsp_o        ),
    .bank_stall_i ( bank_stall_i ),
    .inj_flip_i   ( inj_flip_i   )
  );

  bind bank_rotation_router tcdm_ecc_props u_props (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .req_i      ( req_i      ),
    .op_i       ( op_i       ),
    .gnt_i      ( gnt_o      ),
    .r_valid_i  ( r_valid_o  ),
    .lane_sel_i ( lane_sel   ),
    .bank_req_i ( bank_req_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // failures seen here plus those of the bound router checks
  function automatic int total_errors();
    return err_cnt + int'(tcdm_ecc_subsystem_inst.u_router.u_props.fail_cnt);
  endfunction

  function automatic addr_t rand_addr();
    return ADDR_W'($random(seed));
  endfunction

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic wide_req_t write_req(input addr_t addr);
    wide_req_t r;
    r.op   = OP_WRITE;
    r.addr = addr;
    for (int k = 0; k < `TCDM_NB_LANES; k++) begin
      r.data[k] = $random(seed);
    end
    return r;
  endfunction

  // rewrites what the model holds and clears injected flips
  function automatic wide_req_t model_req(input addr_t addr);
    wide_req_t r;
    r.op   = OP_WRITE;
    r.addr = addr;
    for (int k = 0; k < `TCDM_NB_LANES; k++) begin
      r.data[k] = ref_mem[addr_t'(addr + k)];
    end
    return r;
  endfunction

  function automatic wide_req_t read_req(input addr_t addr);
    wide_req_t r;
    r      = '0;
    r.op   = OP_READ;
    r.addr = addr;
    return r;
  endfunction

  task automatic compare_rsp(input wide_rsp_t got, input wide_rsp_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("Error at %0t: read %h status %0d mask %b, expected %h status %0d mask %b",
               $time, got.data, got.status, got.corrected,
               exp.data, exp.status, exp.corrected);
    end
  endtask

  task automatic compare_status(input ecc_status_e got, input ecc_status_e exp);
    if (got !== exp) begin
      err_cnt++;
      $display("Error at %0t: ECC status %0d, expected %0d", $time, got, exp);
    end
  endtask

  // sampled on the edge so values are from the cycle just ended
  task automatic check_response();
    if (pend_rd && !r_valid_o) begin
      err_cnt++;
      $display("Error at %0t: no r_valid_o one cycle after an accepted read", $time);
    end else if (!pend_rd && r_valid_o) begin
      err_cnt++;
      $display("Error at %0t: r_valid_o high without an accepted read", $time);
    end else if (pend_rd && status_only) begin
      compare_status(rsp_o.status, exp_rsp.status);
    end else if (pend_rd) begin
      compare_rsp(rsp_o, exp_rsp);
    end
    pend_rd = 1'b0;
  endtask

  task automatic take_access(input wide_req_t r);
    addr_t a;
    for (int k = 0; k < `TCDM_NB_LANES; k++) begin
      a = addr_t'(r.addr + k);   // wraps at the top word
      if (r.op == OP_WRITE) begin
        ref_mem[a] = r.data[k];
      end else begin
        exp_rsp.data[k] = ref_mem[a];
      end
    end
    exp_rsp.status    = ECC_OK;
    exp_rsp.corrected = '0;
    status_only       = 1'b0;
    pend_rd           = (r.op == OP_READ);
  endtask

  task automatic wait_grant(input wide_req_t r);
    int waited;
    waited = 0;
    if (!timed_out) begin
      @(posedge clk_i);
      check_response();
      while (!gnt_o && waited < TIMEOUT) begin
        @(posedge clk_i);
        check_response();
        waited++;
      end
      if (gnt_o) begin
        take_access(r);
      end else begin
        timed_out = 1'b1;
        $display("no grant within %0d cycles for the access at word %0d", TIMEOUT, r.addr);
      end
    end
  endtask

  task automatic issue(input wide_req_t r);
    req_i  <= 1'b1;
    wide_i <= r;
    wait_grant(r);
  endtask

  task automatic idle_cycle();
    req_i <= 1'b0;
    @(posedge clk_i);
    check_response();
  endtask

  task automatic stall_test();
    addr_t     addr;
    int        sb;
    int        lane;
    wide_req_t r;
    sb   = rand_below(`TCDM_NB_BANKS);
    lane = rand_below(`TCDM_NB_LANES);
    addr = rand_addr();
    addr[BSEL_W-1:0] = BSEL_W'(sb - lane);   // lane hits the stalled bank
    r = write_req(addr);
    bank_stall_i[sb] <= 1'b1;
    req_i  <= 1'b1;
    wide_i <= r;
    repeat (3 + rand_below(5)) begin
      @(posedge clk_i);
      check_response();
      if (gnt_o) begin
        err_cnt++;
        $display("Error at %0t: grant while bank %0d is stalled", $time, sb);
      end
    end
    bank_stall_i <= '0;
    wait_grant(r);
    idle_cycle();
    issue(read_req(addr));
    idle_cycle();
  endtask

  task automatic flip_test(input int nflips);
    addr_t      addr;
    int         lane;
    int         b0;
    code_word_t mask;
    addr = rand_addr();
    lane = rand_below(`TCDM_NB_LANES);
    b0   = rand_below(CW_W);
    mask = '0;
    mask[b0] = 1'b1;
    if (nflips == 2) begin
      mask[(b0 + 1 + rand_below(CW_W - 1)) % CW_W] = 1'b1;   // a second, distinct bit
    end
    inj_flip_i[BSEL_W'(addr + lane)] <= mask;
    issue(write_req(addr));
    inj_flip_i <= '0;
    idle_cycle();
    issue(read_req(addr));
    exp_rsp.status          = (nflips == 2) ? ECC_UNCORRECTABLE : ECC_CORRECTED;
    exp_rsp.corrected[lane] = (nflips == 1);
    status_only             = (nflips == 2);
    idle_cycle();
    issue(model_req(addr));
    idle_cycle();
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_cnt++;
    if (total_errors() != errs_before || timed_out) begin
      fail_cnt++;
      $display("%s: failed", name);
    end else begin
      $display("%s: passed", name);
    end
  endtask

  initial begin
    int errs;
    req_i        = 1'b0;
    wide_i       = '0;
    bank_stall_i = '0;
    inj_flip_i   = '0;
    rst_ni       = 1'b0;
    err_cnt      = 0;
    test_cnt     = 0;
    fail_cnt     = 0;
    timed_out    = 1'b0;
    pend_rd      = 1'b0;
    status_only  = 1'b0;
    exp_rsp      = '0;
    repeat (3) begin
      @(posedge clk_i);
      check_response();
    end
    rst_ni <= 1'b1;

    errs = total_errors();
    for (int i = 0; i < NWORDS / `TCDM_NB_LANES; i++) begin
      issue(write_req(addr_t'(i * `TCDM_NB_LANES)));   // fill the whole scratchpad
    end
    for (int i = 0; i < 24; i++) begin
      issue(write_req(rand_addr()));
      idle_cycle();
    end
    issue(read_req(addr_t'(NWORDS - 2)));   // wraps past the last bank
    idle_cycle();
    for (int i = 0; i < 32; i++) begin
      issue(read_req(rand_addr()));
      idle_cycle();
    end
    end_test("random writes and reads", errs);

    errs = total_errors();
    for (int i = 0; i < 64; i++) begin
      if (rand_below(2) == 1) begin
        issue(write_req(rand_addr()));
      end else begin
        issue(read_req(rand_addr()));
      end
    end
    idle_cycle();
    end_test("back-to-back accesses", errs);

    errs = total_errors();
    repeat (6) stall_test();
    end_test("stalled bank back-pressure", errs);

    errs = total_errors();
    repeat (6) flip_test(1);
    end_test("single bit correction", errs);

    errs = total_errors();
    repeat (6) flip_test(2);
    end_test("double bit detection", errs);

    errs = total_errors();
    for (int i = 0; i < 16; i++) begin
      issue(write_req(rand_addr()));
    end
    idle_cycle();
    idle_cycle();
    end_test("no response for writes", errs);

    $display("tests run: %0d, failed: %0d, errors: %0d", test_cnt, fail_cnt, total_errors());
    if (total_errors() == 0 && !timed_out) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+include
rtl/tcdm_ecc_pkg.sv
rtl/tcdm_bus_pkg.sv
rtl/ecc_encoder.sv
rtl/ecc_decoder.sv
rtl/bank_rotation_router.sv
rtl/wide_port_frontend.sv
rtl/tcdm_bank.sv
rtl/tcdm_ecc_subsystem.sv
tests/tcdm_ecc_props.sv
tests/tcdm_ecc_tb.sv
